// File: Bender.yml
package:
  name: muldiv

sources:
  - verilog/muldiv_pkg.sv
  - verilog/radix4_unit.sv
  - verilog/booth_mul_serial.sv
  - verilog/restoring_div_serial.sv
  - verilog/muldiv_unit.sv
  - target: test
    files:
      - tb/muldiv_assert.sv
      - tb/muldiv_tb.sv

// File: tb/muldiv_assert.sv
`timescale 1ns/1ns
`default_nettype none

module muldiv_assert import muldiv_pkg::*; #(
    parameter int xlen = xlen_default
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire muldiv_req_t   req,
    input  wire logic          req_valid,
    input  wire logic          busy,
    input  wire muldiv_resp_t  resp,
    input  wire logic          resp_valid
);

    localparam logic [xlen_default-1:0] min_neg = {1'b1, {(xlen_default-1){1'b0}}};

    int                       errors = 0;
    logic                     accept;
    logic                     pending;
    int                       cnt;
    int                       hi_q;
    logic [xlen_default-1:0]  exp_q;
    muldiv_op_e               op_q;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // exact 128-bit product, riscv divide rules
    function automatic logic [xlen_default-1:0] model_result(muldiv_req_t r);
        logic                             a_sgn;
        logic                             b_sgn;
        logic [2*xlen_default-1:0]        prod;
        logic signed [xlen_default-1:0]   sa;
        logic signed [xlen_default-1:0]   sb;
        logic [xlen_default-1:0]          res;
        a_sgn = r.op inside {op_mul, op_mulh, op_mulhsu};
        b_sgn = r.op inside {op_mul, op_mulh};
        prod  = {{xlen_default{a_sgn & r.a[xlen_default-1]}}, r.a}
              * {{xlen_default{b_sgn & r.b[xlen_default-1]}}, r.b};
        sa    = r.a;
        sb    = r.b;
        res   = '0;
        case (r.op)
            op_mul: begin
                res = prod[xlen_default-1:0];
            end
            op_mulh, op_mulhsu, op_mulhu: begin
                res = prod[2*xlen_default-1:xlen_default];
            end
            op_div, op_rem: begin
                if (r.b == '0) begin
                    res = (r.op == op_div) ? '1 : r.a;
                end else if (r.a == min_neg && r.b == '1) begin
                    res = (r.op == op_div) ? r.a : '0;
                end else if (r.op == op_div) begin
                    res = sa / sb;
                end else begin
                    res = sa % sb;
                end
            end
            default: begin
                // divu / remu
                if (r.b == '0) begin
                    res = (r.op == op_divu) ? '1 : r.a;
                end else begin
                    res = (r.op == op_divu) ? r.a / r.b : r.a % r.b;
                end
            end
        endcase
        return res;
    endfunction

    // longest allowed gap from accept to resp_valid
    function automatic int max_latency(muldiv_req_t r);
        logic special;
        special = (r.b == '0) ||
                  ((r.op inside {op_div, op_rem}) && r.a == min_neg && r.b == '1);
        if (r.op inside {op_mul, op_mulh, op_mulhsu, op_mulhu}) begin
            return xlen/2 + 2;
        end
        return special ? 2 : xlen + 2;
    endfunction

    ////////////////////////////////////////
    // request tracking
    ////////////////////////////////////////

    assign accept = req_valid & ~busy;

    // one request in flight, cycles counted from the accept edge
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            cnt     <= 0;
        end else if (accept) begin
            pending <= 1'b1;
            cnt     <= 1;
            exp_q   <= model_result(req);
            op_q    <= req.op;
            hi_q    <= max_latency(req);
        end else if (resp_valid) begin
            pending <= 1'b0;
        end else if (pending) begin
            cnt     <= cnt + 1;
        end
    end

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////

    // idle straight out of reset
    assert property (@(posedge clk) rst |=> (!busy && !resp_valid))
    else begin
        errors++;
        $error("busy or resp_valid high after reset");
    end

    assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
    else begin
        errors++;
        $error("resp_valid held for more than one cycle");
    end

    assert property (@(posedge clk) disable iff (rst) resp_valid |-> resp.result == exp_q)
    else begin
        errors++;
        $error("result for %s expected %h actual %h",
               op_q.name(), $sampled(exp_q), $sampled(resp.result));
    end

    assert property (@(posedge clk) disable iff (rst) resp_valid |-> resp.op == op_q)
    else begin
        errors++;
        $error("resp.op does not match the accepted request");
    end

    // busy spans accept edge through the response pulse
    assert property (@(posedge clk) disable iff (rst) busy == pending)
    else begin
        errors++;
        $error("busy does not cover exactly the operation in flight");
    end

    // response only for an accepted request, and inside the latency window
    assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> (pending && cnt >= 2 && cnt <= hi_q))
    else begin
        errors++;
        $error("response without request or outside latency window, cycle %0d", cnt);
    end

    // missing response
    assert property (@(posedge clk) disable iff (rst) pending |-> cnt <= hi_q)
    else begin
        errors++;
        $error("no response within %0d cycles of accept", hi_q);
    end

endmodule

`default_nettype wire

// File: tb/muldiv_tb.sv
`timescale 1ns/1ns
`default_nettype none

module muldiv_tb
    import muldiv_pkg::*;
();

    localparam int xlen       = 64;
    // cycles to wait for resp_valid before giving up
    localparam int wait_limit = 100;

    logic              clk;
    logic              rst;
    muldiv_req_t       req;
    logic              req_valid;
    logic              busy;
    muldiv_resp_t      resp;
    logic              resp_valid;

    integer            seed;
    int                n_tests;
    int                n_failed;
    muldiv_op_e        op;
    logic [xlen-1:0]   a;
    logic [xlen-1:0]   b;
    logic [xlen-1:0]   corners [5];

    muldiv_unit #(
        .xlen (xlen)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .busy       (busy),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    // checker with reference model rides inside the DUT
    bind muldiv_unit muldiv_assert #(.xlen(xlen)) u_assert (.*);

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // one request, wait, report
    ////////////////////////////////////////

    task automatic run_test(input string name, input muldiv_op_e t_op,
                            input logic [xlen-1:0] t_a, input logic [xlen-1:0] t_b,
                            input bit stray);
        int               cycles;
        int               err_start;
        bit               got;
        logic [xlen-1:0]  result;
        err_start = DUT.u_assert.errors;
        got       = 1'b0;
        cycles    = 0;
        result    = '0;
        @(posedge clk);
        #5;
        req.op    = t_op;
        req.a     = t_a;
        req.b     = t_b;
        req_valid = 1'b1;
        while (!got && cycles < wait_limit) begin
            @(posedge clk);
            #5;
            req_valid = 1'b0;
            if (resp_valid) begin
                got    = 1'b1;
                result = resp.result;
            end else if (stray && cycles == 0) begin
                // strobe while busy, must be dropped
                req.op    = op_divu;
                req.a     = {$random(seed), $random(seed)};
                req.b     = {$random(seed), $random(seed)};
                req_valid = 1'b1;
            end
            cycles++;
        end
        // two more edges so the pulse width and busy checks land in this test
        if (got) begin
            repeat (2) @(posedge clk);
            #5;
        end
        n_tests++;
        if (!got) begin
            n_failed++;
            $display("test %s timed out, no resp_valid within %0d cycles", name, wait_limit);
        end else if (DUT.u_assert.errors != err_start) begin
            n_failed++;
            if (result !== DUT.u_assert.exp_q) begin
                $display("FAILED %s expected %h actual %h",
                         name, DUT.u_assert.exp_q, result);
            end else begin
                $display("test %s broke a protocol rule, see the assertion error", name);
            end
        end else begin
            $display("ok %s result %h", name, result);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        seed       = 32'hdb18_d3b9;
        n_tests    = 0;
        n_failed   = 0;
        // zero, one, minus one, most negative, most positive
        corners[0] = '0;
        corners[1] = 64'd1;
        corners[2] = '1;
        corners[3] = {1'b1, {(xlen-1){1'b0}}};
        corners[4] = {1'b0, {(xlen-1){1'b1}}};
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        // idle cycles, reset assertion watches these
        repeat (3) @(posedge clk);

        // every op against every corner pair
        // covers divide by zero and signed overflow
        for (int o = 0; o < 8; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    op = muldiv_op_e'(o);
                    run_test($sformatf("%s_c%0d_%0d", op.name(), i, j), op,
                             corners[i], corners[j], (i + j) % 4 == 0);
                end
            end
        end

        // random pairs
        for (int o = 0; o < 8; o++) begin
            for (int k = 0; k < 12; k++) begin
                op = muldiv_op_e'(o);
                a  = {$random(seed), $random(seed)};
                b  = {$random(seed), $random(seed)};
                // short multiplier, early finish
                if (k < 4) begin
                    a = a & 64'hff;
                end
                // short divisor, wide quotient
                if (k >= 4 && k < 7) begin
                    b = b & 64'hffff;
                end
                run_test($sformatf("%s_r%0d", op.name(), k), op, a, b, k % 3 == 0);
            end
        end

        $display("tests %0d, passed %0d, failed %0d, assertion errors %0d",
                 n_tests, n_tests - n_failed, n_failed, DUT.u_assert.errors);
        if (n_failed == 0 && DUT.u_assert.errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/muldiv_pkg.sv
verilog/radix4_unit.sv
verilog/booth_mul_serial.sv
verilog/restoring_div_serial.sv
verilog/muldiv_unit.sv
tb/muldiv_assert.sv
tb/muldiv_tb.sv

// File: verilog/booth_mul_serial.sv
`timescale 1ns/1ns
`default_nettype none

module booth_mul_serial import muldiv_pkg::*; #(
    parameter int xlen = xlen_default
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [xlen-1:0]     mul1,
    input  wire logic [xlen-1:0]     mul2,
    input  wire logic                signed1,
    input  wire logic                signed2,
    input  wire logic                mul_valid,
    output logic                     p_valid,
    output logic      [2*xlen-1:0]   p
);

    // accumulator width, two guard bits each side of the product
    localparam int pw        = 2*xlen + 4;
    // one window per bit pair plus the extension window
    localparam int last_iter = xlen/2 + 1;
    localparam int cnt_w     = $clog2(last_iter + 1);

    logic              sgn1;
    logic              sgn2;
    logic [xlen+2:0]   mul1_sr;
    logic [pw-1:0]     mul2_sr;
    logic [pw-1:0]     partial_sum;
    logic              partial_c;
    logic [pw-1:0]     acc;
    logic [pw-1:0]     sum;
    logic              mul_process;
    logic [cnt_w-1:0]  iter_cnt;
    logic              rest_zero;

    // sign extension bits, zero for unsigned operands
    assign sgn1 = signed1 & mul1[xlen-1];
    assign sgn2 = signed2 & mul2[xlen-1];

    ////////////////////////////////////////
    // operand shift registers
    ////////////////////////////////////////

    // multiplier: two extension bits on top, implicit zero below bit 0
    // multiplicand: widened to accumulator size, moves up two per step
    always_ff @(posedge clk) begin
        if (mul_valid) begin
            mul1_sr <= {{2{sgn1}}, mul1, 1'b0};
            mul2_sr <= {{(xlen+4){sgn2}}, mul2};
        end else if (mul_process) begin
            mul1_sr <= {2'b00, mul1_sr[xlen+2:2]};
            mul2_sr <= {mul2_sr[pw-3:0], 2'b00};
        end
    end

    // partial product for the current window
    radix4_unit #(
        .xlen (xlen)
    ) u_radix4 (
        .booth        (mul1_sr[2:0]),
        .multiplicand (mul2_sr),
        .partial_sum  (partial_sum),
        .partial_c    (partial_c)
    );

    ////////////////////////////////////////
    // accumulate
    ////////////////////////////////////////

    // running sum, carry-in completes the two's complement
    assign sum = acc + partial_sum + {{(pw-1){1'b0}}, partial_c};

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            acc <= '0;
        end else if (mul_process) begin
            acc <= sum;
        end
    end

    // product straight off the adder
    assign p = sum[2*xlen-1:0];

    ////////////////////////////////////////
    // iteration control
    ////////////////////////////////////////

    // nothing left above the current window
    assign rest_zero = ~|mul1_sr[xlen+2:1];

    assign p_valid = mul_process &
                     (rest_zero | (iter_cnt == cnt_w'(last_iter)));

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_process <= 1'b0;
            iter_cnt    <= '0;
        end else if (mul_valid) begin
            mul_process <= 1'b1;
            // first window counts as iteration one
            iter_cnt    <= cnt_w'(1);
        end else if (p_valid) begin
            mul_process <= 1'b0;
            iter_cnt    <= '0;
        end else if (mul_process) begin
            iter_cnt    <= iter_cnt + cnt_w'(1);
        end
    end

endmodule

`default_nettype wire

// File: verilog/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // operand width, rv64
    localparam int xlen_default = 64;

    ////////////////////////////////////////
    // operation codes
    ////////////////////////////////////////

    // multiply group first, divide group has bit 2 set
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } muldiv_op_e;

    // request, rs1 in a and rs2 in b
    typedef struct packed {
        muldiv_op_e              op;
        logic [xlen_default-1:0] a;
        logic [xlen_default-1:0] b;
    } muldiv_req_t;

    // response, carries back the op it answers
    typedef struct packed {
        logic [xlen_default-1:0] result;
        muldiv_op_e              op;
    } muldiv_resp_t;

endpackage

`default_nettype wire

// File: verilog/muldiv_unit.sv
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit import muldiv_pkg::*; #(
    parameter int xlen = xlen_default
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire muldiv_req_t  req,
    input  wire logic         req_valid,
    output logic              busy,
    output muldiv_resp_t      resp,
    output logic              resp_valid
);

    logic                 accept;
    logic                 is_div_op;
    logic                 signed1;
    logic                 signed2;
    logic                 div_signed;
    logic                 mul_valid;
    logic                 div_valid;
    muldiv_op_e           op_q;
    logic                 p_valid;
    logic [2*xlen-1:0]    p;
    logic                 div_done;
    logic [xlen-1:0]      quotient;
    logic [xlen-1:0]      remainder;
    logic                 done;
    logic [xlen-1:0]      sel_result;
    muldiv_resp_t         resp_next;

    ////////////////////////////////////////
    // accept and decode
    ////////////////////////////////////////

    // strobes while busy are dropped
    assign accept = req_valid & ~busy;

    // signedness per operand
    always_comb begin
        is_div_op  = 1'b0;
        signed1    = 1'b0;
        signed2    = 1'b0;
        div_signed = 1'b0;
        case (req.op)
            op_mul, op_mulh: begin
                signed1 = 1'b1;
                signed2 = 1'b1;
            end
            // rs1 signed, rs2 unsigned
            op_mulhsu: begin
                signed1 = 1'b1;
            end
            op_div, op_rem: begin
                is_div_op  = 1'b1;
                div_signed = 1'b1;
            end
            op_divu, op_remu: begin
                is_div_op = 1'b1;
            end
            default: begin
                // mulhu, all unsigned
                is_div_op = 1'b0;
            end
        endcase
    end

    // engines latch operands in the accept cycle
    assign mul_valid = accept & ~is_div_op;
    assign div_valid = accept & is_div_op;

    ////////////////////////////////////////
    // engines
    ////////////////////////////////////////

    booth_mul_serial #(
        .xlen (xlen)
    ) u_mul (
        .clk       (clk),
        .rst       (rst),
        .mul1      (req.a[xlen-1:0]),
        .mul2      (req.b[xlen-1:0]),
        .signed1   (signed1),
        .signed2   (signed2),
        .mul_valid (mul_valid),
        .p_valid   (p_valid),
        .p         (p)
    );

    restoring_div_serial #(
        .xlen (xlen)
    ) u_div (
        .clk       (clk),
        .rst       (rst),
        .dividend  (req.a[xlen-1:0]),
        .divisor   (req.b[xlen-1:0]),
        .is_signed (div_signed),
        .div_valid (div_valid),
        .div_done  (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    ////////////////////////////////////////
    // result select
    ////////////////////////////////////////

    // only the strobed engine ever pulses
    assign done = p_valid | div_done;

    always_comb begin
        case (op_q)
            op_mul:                       sel_result = p[xlen-1:0];
            op_mulh, op_mulhsu, op_mulhu: sel_result = p[2*xlen-1:xlen];
            op_div, op_divu:              sel_result = quotient;
            default:                      sel_result = remainder;
        endcase
    end

    assign resp_next.result = sel_result;
    assign resp_next.op     = op_q;

    // op held for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= req.op;
        end
        if (done) begin
            resp <= resp_next;
        end
    end

    // busy drops the cycle after the response pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= done;
            if (accept) begin
                busy <= 1'b1;
            end else if (resp_valid) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/radix4_unit.sv
`timescale 1ns/1ns
`default_nettype none

module radix4_unit import muldiv_pkg::*; #(
    parameter int xlen = xlen_default
) (
    input  wire logic [2:0]          booth,
    input  wire logic [2*xlen+3:0]   multiplicand,
    output logic      [2*xlen+3:0]   partial_sum,
    output logic                     partial_c
);

    // booth window decode
    // 000 / 111 -> 0
    // 001 / 010 -> +m
    // 011       -> +2m
    // 100       -> -2m
    // 101 / 110 -> -m
    // negatives are one's complement, +1 goes out on partial_c
    always_comb begin
        partial_sum = '0;
        partial_c   = 1'b0;
        case (booth)
            3'b001, 3'b010: begin
                partial_sum = multiplicand;
            end
            3'b011: begin
                partial_sum = {multiplicand[2*xlen+2:0], 1'b0};
            end
            3'b100: begin
                partial_sum = ~{multiplicand[2*xlen+2:0], 1'b0};
                partial_c   = 1'b1;
            end
            3'b101, 3'b110: begin
                partial_sum = ~multiplicand;
                partial_c   = 1'b1;
            end
            default: begin
                // all equal bits, nothing to add
                partial_sum = '0;
                partial_c   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/restoring_div_serial.sv
`timescale 1ns/1ns
`default_nettype none

module restoring_div_serial import muldiv_pkg::*; #(
    parameter int xlen = xlen_default
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [xlen-1:0]    dividend,
    input  wire logic [xlen-1:0]    divisor,
    input  wire logic               is_signed,
    input  wire logic               div_valid,
    output logic                    div_done,
    output logic      [xlen-1:0]    quotient,
    output logic      [xlen-1:0]    remainder
);

    localparam int cnt_w = $clog2(xlen + 1);

    logic              a_neg;
    logic              b_neg;
    logic [xlen-1:0]   a_mag;
    logic [xlen-1:0]   b_mag;
    logic              div_zero;
    logic              overflow;
    logic              active;
    logic [cnt_w-1:0]  cnt;
    logic              special_q;
    logic              neg_quo;
    logic              neg_rem;
    logic [xlen-1:0]   rem_q;
    logic [xlen-1:0]   quo_q;
    logic [xlen-1:0]   dvs_q;
    logic [xlen:0]     shifted;
    logic [xlen:0]     diff;
    logic              fits;
    logic [xlen-1:0]   rem_next;
    logic [xlen-1:0]   quo_next;

    ////////////////////////////////////////
    // operand prep
    ////////////////////////////////////////

    assign a_neg = is_signed & dividend[xlen-1];
    assign b_neg = is_signed & divisor[xlen-1];

    // magnitudes, most negative value maps to 2^(xlen-1) unsigned
    assign a_mag = a_neg ? -dividend : dividend;
    assign b_mag = b_neg ? -divisor : divisor;

    // riscv special cases
    assign div_zero = ~|divisor;
    assign overflow = is_signed & (dividend == {1'b1, {(xlen-1){1'b0}}}) & (&divisor);

    ////////////////////////////////////////
    // one quotient bit per cycle
    ////////////////////////////////////////

    // dividend bits shift out of quo_q into the partial remainder
    assign shifted  = {rem_q, quo_q[xlen-1]};
    assign diff     = shifted - {1'b0, dvs_q};
    // no borrow means the divisor fits
    assign fits     = ~diff[xlen];
    assign rem_next = fits ? diff[xlen-1:0] : shifted[xlen-1:0];
    assign quo_next = {quo_q[xlen-2:0], fits};

    always_ff @(posedge clk) begin
        if (div_valid) begin
            dvs_q     <= b_mag;
            special_q <= div_zero | overflow;
            neg_quo   <= a_neg ^ b_neg;
            neg_rem   <= a_neg;
            // special results parked in the datapath registers
            if (div_zero) begin
                quo_q <= '1;
                rem_q <= dividend;
            end else if (overflow) begin
                quo_q <= dividend;
                rem_q <= '0;
            end else begin
                quo_q <= a_mag;
                rem_q <= '0;
            end
        end else if (active) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
        end
    end

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    // last step, or first cycle for special cases
    assign div_done = active & (special_q | (cnt == cnt_w'(xlen)));

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (div_valid) begin
            active <= 1'b1;
            cnt    <= cnt_w'(1);
        end else if (div_done) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (active) begin
            cnt    <= cnt + cnt_w'(1);
        end
    end

    // signs back on, remainder follows dividend
    assign quotient  = special_q ? quo_q : (neg_quo ? -quo_next : quo_next);
    assign remainder = special_q ? rem_q : (neg_rem ? -rem_next : rem_next);

endmodule

`default_nettype wire
